// ==== cdc_pkg.sv ====
`default_nettype none

// crossing structure shared by the fifo blocks
package cdc_pkg;

   //############################
   // synchronizer
   //############################

   // flops in each pointer bit chain, 2 is the usual minimum
   localparam int SYNC_STAGES = 2;

   //############################
   // chaos lfsr
   //############################

   localparam int LFSR_W = 16;                    // lfsr register width

   // galois mask for x^16 + x^14 + x^13 + x^11 + 1
   // maximal length, period 2^16-1
   localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

   // any non-zero value works, all zeros locks the lfsr
   localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

endpackage

`default_nettype wire

// ==== link_pkg.sv ====
`default_nettype none

// payload formats carried across the link
package link_pkg;

   localparam int ADDR_W = 8;    // request address field
   localparam int DATA_W = 16;   // data field, both directions
   localparam int TAG_W  = 4;    // response tag field

   //############################
   // request word, wr -> rd
   //############################

   // 25 bits, msb first
   typedef struct packed {
      logic              is_write;  // 1 write, 0 read request
      logic [ADDR_W-1:0] addr;      // target address
      logic [DATA_W-1:0] data;      // write data, don't care on read
   } req_t;

   //############################
   // response word, rd -> wr
   //############################

   // 20 bits, msb first
   typedef struct packed {
      logic [TAG_W-1:0]  tag;       // echoes requester tag
      logic [DATA_W-1:0] data;      // read data
   } rsp_t;

endpackage

`default_nettype wire

// ==== la_dsync.sv ====
`timescale 1ns/1ps
`default_nettype none

// one bit metastability filter, gray pointer bits only
module la_dsync
  (
   input  logic clk,      // destination clock
   input  logic nreset,   // destination reset, async active low
   input  logic in,       // bit from the other domain
   output logic out       // bit after the last stage
   );

   logic [cdc_pkg::SYNC_STAGES-1:0] sync_q;   // stage 0 may go metastable

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         sync_q <= '0;
      else
      begin
         sync_q[0] <= in;   // first capture
         for (int s = 1; s < cdc_pkg::SYNC_STAGES; s++)
            sync_q[s] <= sync_q[s-1];   // settle
      end
   end

   assign out = sync_q[cdc_pkg::SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== la_chaos_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

// pseudo random full request for producer stress
// galois form, one xor level between flops
module la_chaos_lfsr
  (
   input  logic clk,      // write side clock of the fifo
   input  logic nreset,   // async active low
   output logic chaos     // 1 -> ask for a fake full
   );

   logic [cdc_pkg::LFSR_W-1:0] lfsr_q;     // state
   logic [cdc_pkg::LFSR_W-1:0] lfsr_nxt;   // next state

   //############################
   // next state
   //############################

   // shift right, fold taps in when the bit falling out is 1
   always_comb
   begin
      lfsr_nxt = lfsr_q >> 1;
      if (lfsr_q[0])
         lfsr_nxt = lfsr_nxt ^ cdc_pkg::LFSR_TAPS;
   end

   //############################
   // state register
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         lfsr_q <= cdc_pkg::LFSR_SEED;   // never all zeros
      else
         lfsr_q <= lfsr_nxt;             // free running
   end

   // about half the cycles
   assign chaos = lfsr_q[0];

endmodule

`default_nettype wire

// ==== la_dpram.sv ====
`timescale 1ns/1ps
`default_nettype none

// fifo storage, one write port and one registered read port
// each port on its own clock
module la_dpram
  #(
    parameter type payload_t = logic [7:0],   // word format
    parameter int  DEPTH     = 4              // words, power of two
    )
   (
    // write port
    input  logic                     wr_clk,
    input  logic                     wr_en,     // already qualified by full
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    // read port
    input  logic                     rd_clk,
    input  logic                     rd_en,     // load output register
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data    // valid one cycle after rd_en
    );

   payload_t mem [DEPTH];   // storage array

   //############################
   // write port
   //############################

   always_ff @(posedge wr_clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   //############################
   // read port
   //############################

   // holds between reads, loads even on an empty read
   always_ff @(posedge rd_clk)
   begin
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== la_asyncfifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// dual clock fifo
// gray pointers cross the domains and flags are registered locally
module la_asyncfifo
  #(
    parameter type payload_t = logic [31:0],   // word format
    parameter int  DEPTH     = 4,              // power of two, >= 4
    parameter bit  CHAOS     = 1'b0            // build the random full logic
    )
   (
    // write side
    input  logic     wr_clk,
    input  logic     wr_nreset,
    input  payload_t wr_din,        // word to push
    input  logic     wr_en,         // push strobe
    input  logic     wr_chaosmode,  // random full when set
    output logic     wr_full,       // registered full
    // read side
    input  logic     rd_clk,
    input  logic     rd_nreset,
    input  logic     rd_en,         // pop strobe
    output payload_t rd_dout,       // next cycle after rd_en
    output logic     rd_empty       // registered empty
    );

   localparam int AW = $clog2(DEPTH);   // pointers carry one bit more than this

   // write domain
   logic [AW:0] wr_binptr;
   logic [AW:0] wr_binptr_nxt;
   logic [AW:0] wr_grayptr;
   logic [AW:0] wr_grayptr_nxt;
   logic [AW:0] rd_grayptr_sync;   // read pointer seen on wr_clk
   logic        wr_push;           // accepted write
   logic        wr_chaosfull;      // random full request

   // read domain
   logic [AW:0] rd_binptr;
   logic [AW:0] rd_binptr_nxt;
   logic [AW:0] rd_grayptr;
   logic [AW:0] rd_grayptr_nxt;
   logic [AW:0] wr_grayptr_sync;   // write pointer seen on rd_clk

   //############################
   // write side
   //############################

   assign wr_push       = wr_en & ~wr_full;   // write while full is dropped
   assign wr_binptr_nxt = wr_binptr + {{AW{1'b0}}, wr_push};
   assign wr_grayptr_nxt = wr_binptr_nxt ^ (wr_binptr_nxt >> 1);   // bin to gray

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_binptr  <= '0;
         wr_grayptr <= '0;
      end
      else
      begin
         wr_binptr  <= wr_binptr_nxt;
         wr_grayptr <= wr_grayptr_nxt;
      end
   end

   // full when next write ptr is one lap ahead of the read ptr
   // in gray code the top two bits differ and the rest match
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
         wr_full <= 1'b0;
      else
         wr_full <= (wr_chaosfull & wr_chaosmode) |
                    (wr_grayptr_nxt == {~rd_grayptr_sync[AW:AW-1],
                                        rd_grayptr_sync[AW-2:0]});
   end

   // write ptr into read domain, one chain per bit
   for (genvar i = 0; i <= AW; i++)
   begin : g_wr2rd
      la_dsync u_wrsync
        (
         .clk    (rd_clk),
         .nreset (rd_nreset),
         .in     (wr_grayptr[i]),
         .out    (wr_grayptr_sync[i])
         );
   end

   //############################
   // read side
   //############################

   assign rd_binptr_nxt  = rd_binptr + {{AW{1'b0}}, (rd_en & ~rd_empty)};
   assign rd_grayptr_nxt = rd_binptr_nxt ^ (rd_binptr_nxt >> 1);

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_binptr  <= '0;
         rd_grayptr <= '0;
      end
      else
      begin
         rd_binptr  <= rd_binptr_nxt;
         rd_grayptr <= rd_grayptr_nxt;
      end
   end

   // empty when the next read ptr catches the synced write ptr
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
         rd_empty <= 1'b1;   // nothing stored out of reset
      else
         rd_empty <= (rd_grayptr_nxt == wr_grayptr_sync);
   end

   // read ptr back into write domain
   for (genvar i = 0; i <= AW; i++)
   begin : g_rd2wr
      la_dsync u_rdsync
        (
         .clk    (wr_clk),
         .nreset (wr_nreset),
         .in     (rd_grayptr[i]),
         .out    (rd_grayptr_sync[i])
         );
   end

   //############################
   // storage
   //############################

   la_dpram #(
      .payload_t (payload_t),
      .DEPTH     (DEPTH)
   ) u_mem (
      .wr_clk  (wr_clk),
      .wr_en   (wr_push),
      .wr_addr (wr_binptr[AW-1:0]),   // drop the wrap bit
      .wr_data (wr_din),
      .rd_clk  (rd_clk),
      .rd_en   (rd_en),               // loads even when empty
      .rd_addr (rd_binptr[AW-1:0]),
      .rd_data (rd_dout)
   );

   //############################
   // chaos full
   //############################

   if (CHAOS)
   begin : g_chaos
      la_chaos_lfsr u_chaos
        (
         .clk    (wr_clk),
         .nreset (wr_nreset),
         .chaos  (wr_chaosfull)
         );
   end
   else
   begin : g_nochaos
      assign wr_chaosfull = 1'b0;   // mode pin has no effect
   end

endmodule

`default_nettype wire

// ==== cdc_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// two way link between wr_clk and rd_clk domains
// requests go wr -> rd, responses come back rd -> wr
module cdc_link_top
  #(
    parameter int REQ_DEPTH = 8,      // request fifo words
    parameter int RSP_DEPTH = 4,      // response fifo words
    parameter bit CHAOS     = 1'b1    // build random full in both fifos
    )
   (
    // clocks and resets
    input  logic           wr_clk,
    input  logic           wr_nreset,
    input  logic           rd_clk,
    input  logic           rd_nreset,
    input  logic           chaos_mode,    // stress the producers
    // request path, write domain side
    input  logic           req_wr_en,
    input  link_pkg::req_t req_wr_data,
    output logic           req_full,
    // request path, read domain side
    input  logic           req_rd_en,
    output link_pkg::req_t req_rd_data,
    output logic           req_empty,
    // response path, read domain side
    input  logic           rsp_wr_en,
    input  link_pkg::rsp_t rsp_wr_data,
    output logic           rsp_full,
    // response path, write domain side
    input  logic           rsp_rd_en,
    output link_pkg::rsp_t rsp_rd_data,
    output logic           rsp_empty
    );

   //############################
   // request fifo
   //############################

   la_asyncfifo #(
      .payload_t (link_pkg::req_t),
      .DEPTH     (REQ_DEPTH),
      .CHAOS     (CHAOS)
   ) u_req_fifo (
      .wr_clk       (wr_clk),
      .wr_nreset    (wr_nreset),
      .wr_din       (req_wr_data),
      .wr_en        (req_wr_en),
      .wr_chaosmode (chaos_mode),
      .wr_full      (req_full),
      .rd_clk       (rd_clk),
      .rd_nreset    (rd_nreset),
      .rd_en        (req_rd_en),
      .rd_dout      (req_rd_data),
      .rd_empty     (req_empty)
   );

   //############################
   // response fifo
   //############################

   // same block, clocks swapped
   la_asyncfifo #(
      .payload_t (link_pkg::rsp_t),
      .DEPTH     (RSP_DEPTH),
      .CHAOS     (CHAOS)
   ) u_rsp_fifo (
      .wr_clk       (rd_clk),       // producer lives on rd_clk
      .wr_nreset    (rd_nreset),
      .wr_din       (rsp_wr_data),
      .wr_en        (rsp_wr_en),
      .wr_chaosmode (chaos_mode),   // resampled on rd_clk inside
      .wr_full      (rsp_full),
      .rd_clk       (wr_clk),       // consumer back on wr_clk
      .rd_nreset    (wr_nreset),
      .rd_en        (rsp_rd_en),
      .rd_dout      (rsp_rd_data),
      .rd_empty     (rsp_empty)
   );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, starts low
module tb_clock_gen
  #(
    parameter real PERIOD = 10.0   // ns
    )
   (
    output logic clk
    );

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2.0) clk = ~clk;   // 50% duty
   end

endmodule

`default_nettype wire

// ==== tb_cdc_link.sv ====
`timescale 1ns/1ps
`default_nettype none

// directed tests for the two way cdc link
module tb_cdc_link;

   localparam int REQ_DEPTH = 8;
   localparam int RSP_DEPTH = 4;
   localparam int STREAM_N  = 200;   // request words, streaming test
   localparam int RSP_N     = 100;   // response words
   localparam int CHAOS_N   = 100;   // request words under chaos
   // every word tried over all tests including 3 dropped on overflow
   localparam int TOTAL_N     = 1 + REQ_DEPTH + 3 + STREAM_N + RSP_N + CHAOS_N;
   localparam int CYCLE_LIMIT = TOTAL_N * 20 + 500;   // wr_clk cycles

   logic           wr_clk, rd_clk;
   logic           wr_nreset, rd_nreset;
   logic           chaos_mode;
   logic           req_wr_en, req_full, req_rd_en, req_empty;
   link_pkg::req_t req_wr_data, req_rd_data;
   logic           rsp_wr_en, rsp_full, rsp_rd_en, rsp_empty;
   link_pkg::rsp_t rsp_wr_data, rsp_rd_data;

   integer         seed;          // $random state
   int             errors;        // all failed checks
   int             test_base;     // errors when the current test began
   int             tests_ok, tests_bad;
   int             cycles = 0;    // watchdog count
   int             chaos_hits;    // full seen with a near empty fifo
   string          cur_test;
   link_pkg::req_t req_q[$];      // expected requests in arrival order
   link_pkg::rsp_t rsp_q[$];      // expected responses

   tb_clock_gen #(.PERIOD(40.0)) u_wr_clk_gen (.clk(wr_clk));
   tb_clock_gen #(.PERIOD(28.0)) u_rd_clk_gen (.clk(rd_clk));   // ratio not integer

   cdc_link_top #(
      .REQ_DEPTH (REQ_DEPTH),
      .RSP_DEPTH (RSP_DEPTH),
      .CHAOS     (1'b1)
   ) u_cdc_link_top (
      .wr_clk      (wr_clk),
      .wr_nreset   (wr_nreset),
      .rd_clk      (rd_clk),
      .rd_nreset   (rd_nreset),
      .chaos_mode  (chaos_mode),
      .req_wr_en   (req_wr_en),
      .req_wr_data (req_wr_data),
      .req_full    (req_full),
      .req_rd_en   (req_rd_en),
      .req_rd_data (req_rd_data),
      .req_empty   (req_empty),
      .rsp_wr_en   (rsp_wr_en),
      .rsp_wr_data (rsp_wr_data),
      .rsp_full    (rsp_full),
      .rsp_rd_en   (rsp_rd_en),
      .rsp_rd_data (rsp_rd_data),
      .rsp_empty   (rsp_empty)
   );

   // watchdog on the write clock
   always @(posedge wr_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("test %s stalled, no progress within %0d wr_clk cycles",
                  cur_test, CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   //############################
   // helpers
   //############################

   function automatic bit chance(input int pct);
      int unsigned r;
      r = $random(seed);
      return (r % 100) < pct;
   endfunction

   function automatic link_pkg::req_t rand_req();
      logic [31:0] r;
      r = $random(seed);
      return r[$bits(link_pkg::req_t)-1:0];   // low bits fill the word
   endfunction

   function automatic link_pkg::rsp_t rand_rsp();
      logic [31:0] r;
      r = $random(seed);
      return r[$bits(link_pkg::rsp_t)-1:0];
   endfunction

   task automatic check_req(input link_pkg::req_t exp, input link_pkg::req_t act);
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_rsp(input link_pkg::rsp_t exp, input link_pkg::rsp_t act);
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_flag(input logic exp, input logic act);
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %b, actual %b", cur_test, exp, act);
      end
   endtask

   task automatic no_word(input string path);
      errors++;
      $display("%s: %s word read out that was never written", cur_test, path);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_base = errors;
      repeat (6) @(posedge wr_clk);   // let pointers settle across
   endtask

   task automatic end_test();
      if (req_q.size() != 0 || rsp_q.size() != 0)
      begin
         errors++;
         $display("%s: %0d request and %0d response words never arrived",
                  cur_test, req_q.size(), rsp_q.size());
      end
      if (errors == test_base)
      begin
         tests_ok++;
         $display("test %s: ok", cur_test);
      end
      else
      begin
         tests_bad++;
         $display("test %s: bad, %0d errors", cur_test, errors - test_base);
      end
   endtask

   //############################
   // traffic, request path
   //############################

   // pushes count accepted words and holds a blocked word
   task automatic produce_req(input int count, input int en_pct);
      int sent;
      sent = 0;
      while (sent < count)
      begin
         @(posedge wr_clk);
         if (req_full && req_q.size() < 2)
            chaos_hits++;   // too shallow for a real full
         if (req_wr_en && !req_full)
         begin
            req_q.push_back(req_wr_data);
            sent++;
         end
         if (sent == count)
            req_wr_en <= 1'b0;
         else if (!(req_wr_en && req_full))
         begin
            req_wr_en   <= chance(en_pct);
            req_wr_data <= rand_req();
         end
      end
   endtask

   // pops count words and checks each one rd cycle after its pop
   task automatic consume_req(input int count, input int en_pct);
      int             got;
      bit             pending;
      link_pkg::req_t exp;
      got     = 0;
      pending = 1'b0;
      while (got < count || pending)
      begin
         @(posedge rd_clk);
         if (pending)
            check_req(exp, req_rd_data);
         pending = 1'b0;
         if (req_rd_en && !req_empty)
         begin
            got++;
            pending = (req_q.size() != 0);
            if (pending)
               exp = req_q.pop_front();
            else
               no_word("request");
         end
         req_rd_en <= (got < count) && chance(en_pct);
      end
   endtask

   //############################
   // traffic, response path
   //############################

   task automatic produce_rsp(input int count, input int en_pct);
      int sent;
      sent = 0;
      while (sent < count)
      begin
         @(posedge rd_clk);
         if (rsp_wr_en && !rsp_full)
         begin
            rsp_q.push_back(rsp_wr_data);
            sent++;
         end
         if (sent == count)
            rsp_wr_en <= 1'b0;
         else if (!(rsp_wr_en && rsp_full))
         begin
            rsp_wr_en   <= chance(en_pct);
            rsp_wr_data <= rand_rsp();
         end
      end
   endtask

   // request fifo idle meanwhile so its full must stay low
   task automatic consume_rsp(input int count, input int en_pct);
      int             got;
      bit             pending;
      link_pkg::rsp_t exp;
      got     = 0;
      pending = 1'b0;
      while (got < count || pending)
      begin
         @(posedge wr_clk);
         check_flag(1'b0, req_full);
         if (pending)
            check_rsp(exp, rsp_rd_data);
         pending = 1'b0;
         if (rsp_rd_en && !rsp_empty)
         begin
            got++;
            pending = (rsp_q.size() != 0);
            if (pending)
               exp = rsp_q.pop_front();
            else
               no_word("response");
         end
         rsp_rd_en <= (got < count) && chance(en_pct);
      end
   endtask

   //############################
   // tests
   //############################

   task automatic test_reset();
      start_test("reset");
      @(posedge wr_clk);
      check_flag(1'b0, req_full);
      check_flag(1'b1, rsp_empty);
      @(posedge rd_clk);
      check_flag(1'b1, req_empty);
      check_flag(1'b0, rsp_full);
      end_test();
   endtask

   task automatic test_single();
      start_test("single");
      fork
         produce_req(1, 100);
         consume_req(1, 100);
      join
      @(posedge rd_clk);
      check_flag(1'b1, req_empty);   // popped the only word
      end_test();
   endtask

   // read side idle while DEPTH writes fit and 3 more drop
   task automatic test_fill_overflow();
      start_test("fill_overflow");
      @(posedge wr_clk);
      req_wr_en   <= 1'b1;
      req_wr_data <= rand_req();
      for (int i = 1; i <= REQ_DEPTH + 3; i++)
      begin
         @(posedge wr_clk);
         check_flag(i > REQ_DEPTH, req_full);   // high from the edge after the last fit
         if (i <= REQ_DEPTH)
            req_q.push_back(req_wr_data);       // only the first DEPTH fit
         req_wr_en   <= (i < REQ_DEPTH + 3);
         req_wr_data <= rand_req();
      end
      consume_req(REQ_DEPTH, 100);
      @(posedge rd_clk);
      check_flag(1'b1, req_empty);   // nothing beyond DEPTH got in
      end_test();
   endtask

   task automatic test_stream();
      start_test("stream");
      fork
         produce_req(STREAM_N, 80);
         consume_req(STREAM_N, 50);   // random back-pressure
      join
      end_test();
   endtask

   task automatic test_response();
      start_test("response");
      fork
         produce_rsp(RSP_N, 80);
         consume_rsp(RSP_N, 60);
      join
      end_test();
   endtask

   task automatic test_chaos();
      start_test("chaos");
      chaos_hits = 0;
      chaos_mode <= 1'b1;
      fork
         produce_req(CHAOS_N, 100);
         consume_req(CHAOS_N, 75);
      join
      if (chaos_hits == 0)
      begin
         errors++;
         $display("%s: req_full never rose while the fifo was nearly empty", cur_test);
      end
      @(posedge wr_clk);
      chaos_mode <= 1'b0;
      end_test();
   endtask

   //############################
   // main sequence
   //############################

   initial
   begin
      seed        = 32'h29f26591;
      errors      = 0;
      test_base   = 0;
      tests_ok    = 0;
      tests_bad   = 0;
      chaos_hits  = 0;
      cur_test    = "startup";
      wr_nreset   = 1'b0;   // both domains held in reset
      rd_nreset   = 1'b0;
      chaos_mode  = 1'b0;
      req_wr_en   = 1'b0;
      req_wr_data = '0;
      req_rd_en   = 1'b0;
      rsp_wr_en   = 1'b0;
      rsp_wr_data = '0;
      rsp_rd_en   = 1'b0;
      fork
         begin
            repeat (2) @(posedge wr_clk);
            wr_nreset <= 1'b1;
         end
         begin
            repeat (2) @(posedge rd_clk);
            rd_nreset <= 1'b1;
         end
      join
      test_reset();
      test_single();
      test_fill_overflow();
      test_stream();
      test_response();
      test_chaos();
      $display("summary: %0d tests ok, %0d tests bad, %0d check errors",
               tests_ok, tests_bad, errors);
      if (tests_bad == 0 && errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
cdc_pkg.sv
link_pkg.sv
la_dsync.sv
la_chaos_lfsr.sv
la_dpram.sv
la_asyncfifo.sv
cdc_link_top.sv
tb_clock_gen.sv
tb_cdc_link.sv
